/* logic/mm_pkg.sv */
`default_nettype none

package mm_pkg;

    ////////////////////
    // Sizes and widths
    ////////////////////

    // Width of one matrix element
    parameter int DATA_W = 8;

    // Width of a memory address and of an address stride
    parameter int ADDR_W   = 10;
    parameter int STRIDE_W = 8;

    // Rows and columns of the mesh, also the number of lanes in one memory word
    parameter int ARRAY_N = 4;

    // Width of the cycle counter in the sequencer
    parameter int CNT_W = 8;

    ////////////////////
    // Fixed cycle counts
    ////////////////////

    // Pipeline depth of the MAC inside each PE
    parameter int MAC_STAGES = 3;

    // The last product reaches the far corner PE's accumulator one cycle before this count
    parameter int LATCH_CYCLE = 4 * ARRAY_N - ARRAY_N - 1 + MAC_STAGES;

    // Done follows the latch once the result columns have been shifted out
    parameter int DONE_CYCLE = LATCH_CYCLE + MAC_STAGES;

    ////////////////////
    // Types
    ////////////////////

    // One memory word where lane k is element k
    typedef logic [ARRAY_N-1:0][DATA_W-1:0] lane_vec_t;

    // Address setting of one matrix in memory
    typedef struct packed {
        logic [ADDR_W-1:0]   base;
        logic [STRIDE_W-1:0] stride;
    } mat_ptr_t;

    // Validity masks where a zero bit kills a lane or a whole fetch step
    typedef struct packed {
        logic [ARRAY_N-1:0] a_rows;
        logic [ARRAY_N-1:0] inner;
        logic [ARRAY_N-1:0] b_cols;
    } mm_masks_t;

endpackage

`default_nettype wire

/* logic/mm_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module mm_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start_mat_mul,
    output logic [mm_pkg::CNT_W-1:0] clk_cnt,
    output logic                     row_latch,
    output logic                     done_mat_mul
);

    ////////////////////
    // Cycle counter
    ////////////////////

    // Holds at zero while idle, then counts every edge of the run
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    ////////////////////
    // Decoded strobes
    ////////////////////

    // All accumulators are final while the counter sits at the latch count
    assign row_latch = (clk_cnt == mm_pkg::CNT_W'(mm_pkg::LATCH_CYCLE));

    // Done is a single cycle pulse once the drain has finished
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            done_mat_mul <= 1'b0;
        end else begin
            done_mat_mul <= (clk_cnt == mm_pkg::CNT_W'(mm_pkg::DONE_CYCLE));
        end
    end

endmodule

`default_nettype wire

/* logic/operand_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_feeder (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_mat_mul,
    input  logic [mm_pkg::CNT_W-1:0]  clk_cnt,
    input  mm_pkg::mat_ptr_t          ptr,
    input  logic [mm_pkg::ARRAY_N-1:0] lane_mask,
    input  logic [mm_pkg::ARRAY_N-1:0] step_mask,
    input  mm_pkg::lane_vec_t         mem_data,
    output logic [mm_pkg::ADDR_W-1:0] mem_addr,
    output mm_pkg::lane_vec_t         skewed
);

    // Enough bits to count every fetch step plus the idle value
    localparam int ACC_W = $clog2(mm_pkg::ARRAY_N + 1);

    logic              mem_access;
    logic [ACC_W-1:0]  acc_cnt;
    logic              data_valid;
    mm_pkg::lane_vec_t masked;

    ////////////////////
    // Address generation
    ////////////////////

    // The idle address parks one stride below base and the first step loads base itself
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul || clk_cnt >= mm_pkg::CNT_W'(mm_pkg::ARRAY_N)) begin
            mem_addr   <= ptr.base - mm_pkg::ADDR_W'(ptr.stride);
            mem_access <= 1'b0;
        end else if (clk_cnt == '0) begin
            mem_addr   <= ptr.base;
            mem_access <= 1'b1;
        end else begin
            mem_addr   <= mem_addr + mm_pkg::ADDR_W'(ptr.stride);
            mem_access <= 1'b1;
        end
    end

    ////////////////////
    // Data valid
    ////////////////////

    // Counts accesses one cycle late, which lines it up with the memory read data
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul || !mem_access) begin
            acc_cnt <= '0;
        end else begin
            acc_cnt <= acc_cnt + 1'b1;
        end
    end

    // A count of k+1 means word k is on the bus
    always_comb begin
        data_valid = 1'b0;
        for (int k = 0; k < mm_pkg::ARRAY_N; k++) begin
            if (acc_cnt == ACC_W'(k + 1) && step_mask[k]) begin
                data_valid = 1'b1;
            end
        end
    end

    // Invalid steps and masked lanes feed zeros into the mesh
    always_comb begin
        for (int k = 0; k < mm_pkg::ARRAY_N; k++) begin
            masked[k] = (data_valid && lane_mask[k]) ? mem_data[k] : '0;
        end
    end

    ////////////////////
    // Skew
    ////////////////////

    // Lane k goes through k registers so each PE sees its operands together
    for (genvar k = 0; k < mm_pkg::ARRAY_N; k++) begin : g_lane
        if (k == 0) begin : g_direct
            assign skewed[k] = masked[k];
        end else begin : g_delay
            logic [k-1:0][mm_pkg::DATA_W-1:0] taps;

            always_ff @(posedge clk) begin
                if (reset || !start_mat_mul) begin
                    taps <= '0;
                end else begin
                    taps[0] <= masked[k];
                    for (int s = 1; s < k; s++) begin
                        taps[s] <= taps[s-1];
                    end
                end
            end

            assign skewed[k] = taps[k-1];
        end
    end

endmodule

`default_nettype wire

/* logic/processing_element.sv */
`timescale 1ns/1ps
`default_nettype none

module processing_element #(
    parameter int DATA_W = mm_pkg::DATA_W
) (
    input  logic              clk,
    input  logic              clear,
    input  logic [DATA_W-1:0] in_a,
    input  logic [DATA_W-1:0] in_b,
    output logic [DATA_W-1:0] out_a,
    output logic [DATA_W-1:0] out_b,
    output logic [DATA_W-1:0] acc
);

    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] b_q;
    logic [DATA_W-1:0] prod;

    // Operands move on to the right and downward neighbours one cycle later
    always_ff @(posedge clk) begin
        if (clear) begin
            out_a <= '0;
            out_b <= '0;
        end else begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

    ////////////////////
    // Three stage MAC
    ////////////////////

    // Product and sum both keep only the low DATA_W bits
    always_ff @(posedge clk) begin
        if (clear) begin
            a_q  <= '0;
            b_q  <= '0;
            prod <= '0;
            acc  <= '0;
        end else begin
            a_q  <= in_a;
            b_q  <= in_b;
            prod <= a_q * b_q;
            acc  <= acc + prod;
        end
    end

endmodule

`default_nettype wire

/* logic/pe_array.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_array #(
    parameter int DATA_W = mm_pkg::DATA_W
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     start_mat_mul,
    input  mm_pkg::lane_vec_t                        a_lanes,
    input  mm_pkg::lane_vec_t                        b_lanes,
    output mm_pkg::lane_vec_t [mm_pkg::ARRAY_N-1:0]  c_rows
);

    localparam int N = mm_pkg::ARRAY_N;

    // a_h[i][j] enters PE(i,j) from the left and b_v[i][j] enters it from above
    logic [DATA_W-1:0] a_h [N][N+1];
    logic [DATA_W-1:0] b_v [N+1][N];
    logic              clear;

    // Accumulators start from zero for every new run
    assign clear = reset || !start_mat_mul;

    ////////////////////
    // Mesh edges
    ////////////////////

    for (genvar i = 0; i < N; i++) begin : g_edge
        assign a_h[i][0] = a_lanes[i];
        assign b_v[0][i] = b_lanes[i];
    end

    ////////////////////
    // PE mesh
    ////////////////////

    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            processing_element #(
                .DATA_W(DATA_W)
            ) i_pe (
                .clk  (clk),
                .clear(clear),
                .in_a (a_h[i][j]),
                .in_b (b_v[i][j]),
                .out_a(a_h[i][j+1]),
                .out_b(b_v[i+1][j]),
                .acc  (c_rows[i][j])
            );
        end
    end

endmodule

`default_nettype wire

/* logic/result_drain.sv */
`timescale 1ns/1ps
`default_nettype none

module result_drain (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start_mat_mul,
    input  logic                                    row_latch,
    input  logic                                    done_mat_mul,
    input  mm_pkg::mat_ptr_t                        c_ptr,
    input  mm_pkg::lane_vec_t [mm_pkg::ARRAY_N-1:0] c_rows,
    output mm_pkg::lane_vec_t                       c_data_out,
    output logic [mm_pkg::ADDR_W-1:0]               c_addr,
    output logic                                    c_data_available
);

    localparam int N = mm_pkg::ARRAY_N;

    mm_pkg::lane_vec_t [N-1:0] cols;
    mm_pkg::lane_vec_t [N-2:0] col_q;

    // Column j of C gathers element j of every row
    always_comb begin
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                cols[j][i] = c_rows[i][j];
            end
        end
    end

    ////////////////////
    // Column shifter
    ////////////////////

    // Column 0 goes straight to the output and the rest wait in col_q
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            c_data_available <= 1'b0;
            c_addr           <= c_ptr.base - mm_pkg::ADDR_W'(c_ptr.stride);
            c_data_out       <= '0;
            col_q            <= '0;
        end else if (row_latch) begin
            c_data_available <= 1'b1;
            c_addr           <= c_ptr.base;
            c_data_out       <= cols[0];
            for (int j = 1; j < N; j++) begin
                col_q[j-1] <= cols[j];
            end
        end else if (done_mat_mul) begin
            c_data_available <= 1'b0;
            c_addr           <= c_ptr.base - mm_pkg::ADDR_W'(c_ptr.stride);
            c_data_out       <= '0;
            col_q            <= '0;
        end else if (c_data_available) begin
            // Zeros are shifted in behind the last column
            c_addr     <= c_addr + mm_pkg::ADDR_W'(c_ptr.stride);
            c_data_out <= col_q[0];
            for (int k = 0; k < N - 2; k++) begin
                col_q[k] <= col_q[k+1];
            end
            col_q[N-2] <= '0;
        end
    end

endmodule

`default_nettype wire

/* logic/mm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mm_top #(
    parameter int DATA_W = mm_pkg::DATA_W
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_mat_mul,
    input  mm_pkg::mat_ptr_t          mat_a,
    input  mm_pkg::mat_ptr_t          mat_b,
    input  mm_pkg::mat_ptr_t          mat_c,
    input  mm_pkg::mm_masks_t         masks,
    input  mm_pkg::lane_vec_t         a_data,
    input  mm_pkg::lane_vec_t         b_data,
    output logic [mm_pkg::ADDR_W-1:0] a_addr,
    output logic [mm_pkg::ADDR_W-1:0] b_addr,
    output logic [mm_pkg::ADDR_W-1:0] c_addr,
    output mm_pkg::lane_vec_t         c_data_out,
    output logic                      c_data_available,
    output logic                      done_mat_mul
);

    logic [mm_pkg::CNT_W-1:0]                clk_cnt;
    logic                                    row_latch;
    mm_pkg::lane_vec_t                       a_skewed;
    mm_pkg::lane_vec_t                       b_skewed;
    mm_pkg::lane_vec_t [mm_pkg::ARRAY_N-1:0] c_rows;

    ////////////////////
    // Control
    ////////////////////

    mm_sequencer i_sequencer (
        .clk          (clk),
        .reset        (reset),
        .start_mat_mul(start_mat_mul),
        .clk_cnt      (clk_cnt),
        .row_latch    (row_latch),
        .done_mat_mul (done_mat_mul)
    );

    ////////////////////
    // Operand feeders
    ////////////////////

    // A enters the mesh along the rows
    operand_feeder i_feed_a (
        .clk          (clk),
        .reset        (reset),
        .start_mat_mul(start_mat_mul),
        .clk_cnt      (clk_cnt),
        .ptr          (mat_a),
        .lane_mask    (masks.a_rows),
        .step_mask    (masks.inner),
        .mem_data     (a_data),
        .mem_addr     (a_addr),
        .skewed       (a_skewed)
    );

    // B enters the mesh along the columns
    operand_feeder i_feed_b (
        .clk          (clk),
        .reset        (reset),
        .start_mat_mul(start_mat_mul),
        .clk_cnt      (clk_cnt),
        .ptr          (mat_b),
        .lane_mask    (masks.b_cols),
        .step_mask    (masks.inner),
        .mem_data     (b_data),
        .mem_addr     (b_addr),
        .skewed       (b_skewed)
    );

    ////////////////////
    // Mesh and drain
    ////////////////////

    pe_array #(
        .DATA_W(DATA_W)
    ) i_pe_array (
        .clk          (clk),
        .reset        (reset),
        .start_mat_mul(start_mat_mul),
        .a_lanes      (a_skewed),
        .b_lanes      (b_skewed),
        .c_rows       (c_rows)
    );

    result_drain i_drain (
        .clk             (clk),
        .reset           (reset),
        .start_mat_mul   (start_mat_mul),
        .row_latch       (row_latch),
        .done_mat_mul    (done_mat_mul),
        .c_ptr           (mat_c),
        .c_rows          (c_rows),
        .c_data_out      (c_data_out),
        .c_addr          (c_addr),
        .c_data_available(c_data_available)
    );

endmodule

`default_nettype wire

/* verif/mm_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mm_assertions (
    input logic                      clk,
    input logic                      reset,
    input logic                      start_mat_mul,
    input logic                      done_mat_mul,
    input logic                      c_data_available,
    input logic [mm_pkg::ADDR_W-1:0] a_addr,
    input logic [mm_pkg::ADDR_W-1:0] b_addr,
    input logic [mm_pkg::ADDR_W-1:0] c_addr
);

    // Done is a one cycle pulse
    done_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul
    ) else $error("done_mat_mul was high on two consecutive cycles");

    // No C word is offered in any cycle where start is low
    idle_no_data: assert property (
        @(posedge clk) disable iff (reset)
        !start_mat_mul |-> !c_data_available
    ) else $error("c_data_available was high while start_mat_mul was low");

    // Idle addresses park one stride below base and do not move
    idle_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        !start_mat_mul && !$past(start_mat_mul)
            |-> $stable(a_addr) && $stable(b_addr) && $stable(c_addr)
    ) else $error("a memory address moved while start_mat_mul was low");

endmodule

`default_nettype wire

/* verif/mm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mm_tb;

    localparam int N         = mm_pkg::ARRAY_N;
    localparam int MEM_WORDS = 2 ** mm_pkg::ADDR_W;
    localparam int FIELDS    = 17;
    localparam int MAX_TESTS = 32;

    // Counted in rising edges, the first one being the edge that sees start high
    localparam int FIRST_WORD_CYCLE = 15;
    localparam int DONE_PULSE_CYCLE = 18;

    logic                      clk;
    logic                      reset;
    logic                      start_mat_mul;
    mm_pkg::mat_ptr_t          mat_a;
    mm_pkg::mat_ptr_t          mat_b;
    mm_pkg::mat_ptr_t          mat_c;
    mm_pkg::mm_masks_t         masks;
    mm_pkg::lane_vec_t         a_data;
    mm_pkg::lane_vec_t         b_data;
    logic [mm_pkg::ADDR_W-1:0] a_addr;
    logic [mm_pkg::ADDR_W-1:0] b_addr;
    logic [mm_pkg::ADDR_W-1:0] c_addr;
    mm_pkg::lane_vec_t         c_data_out;
    logic                      c_data_available;
    logic                      done_mat_mul;

    mm_pkg::lane_vec_t         a_mem [MEM_WORDS];
    mm_pkg::lane_vec_t         b_mem [MEM_WORDS];
    logic [mm_pkg::ADDR_W-1:0] a_addr_q;
    logic [mm_pkg::ADDR_W-1:0] b_addr_q;
    logic [31:0]               pattern [MAX_TESTS * FIELDS];
    logic [7:0]                a_mat [N][N];
    logic [7:0]                b_mat [N][N];
    mm_pkg::lane_vec_t         exp_col [N];
    mm_pkg::mat_ptr_t          next_a;
    mm_pkg::mat_ptr_t          next_b;
    mm_pkg::mat_ptr_t          next_c;
    mm_pkg::mm_masks_t         next_masks;
    int                        num_tests;
    logic                      tests_loaded;

    mm_top #(
        .DATA_W(mm_pkg::DATA_W)
    ) i_dut (
        .clk             (clk),
        .reset           (reset),
        .start_mat_mul   (start_mat_mul),
        .mat_a           (mat_a),
        .mat_b           (mat_b),
        .mat_c           (mat_c),
        .masks           (masks),
        .a_data          (a_data),
        .b_data          (b_data),
        .a_addr          (a_addr),
        .b_addr          (b_addr),
        .c_addr          (c_addr),
        .c_data_out      (c_data_out),
        .c_data_available(c_data_available),
        .done_mat_mul    (done_mat_mul)
    );

    bind mm_top mm_assertions i_assertions (
        .clk             (clk),
        .reset           (reset),
        .start_mat_mul   (start_mat_mul),
        .done_mat_mul    (done_mat_mul),
        .c_data_available(c_data_available),
        .a_addr          (a_addr),
        .b_addr          (b_addr),
        .c_addr          (c_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // Memory models
    ////////////////////

    // The word for the address seen in one cycle is on the bus in the next one
    always @(negedge clk) begin
        a_data   = a_mem[a_addr_q];
        b_data   = b_mem[b_addr_q];
        a_addr_q = a_addr;
        b_addr_q = b_addr;
    end

    // Background content mixes all address bits so stray reads are easy to spot
    function automatic mm_pkg::lane_vec_t fill_word(input int addr, input int salt);
        mm_pkg::lane_vec_t w;
        for (int k = 0; k < N; k++) begin
            w[k] = 8'((addr * 29) ^ (addr >> 3) ^ (k * 71) ^ salt);
        end
        return w;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Masked operands drop out of the sum, which wraps at 8 bits
    function automatic logic [7:0] model_element(input int i, input int j);
        int sum;
        int a_v;
        int b_v;
        sum = 0;
        for (int k = 0; k < N; k++) begin
            a_v = (next_masks.a_rows[i] && next_masks.inner[k]) ? int'(a_mat[i][k]) : 0;
            b_v = (next_masks.b_cols[j] && next_masks.inner[k]) ? int'(b_mat[k][j]) : 0;
            sum = (sum + a_v * b_v) % 256;
        end
        return 8'(sum);
    endfunction

    ////////////////////
    // Test steps
    ////////////////////

    task automatic load_test(input int t);
        int                p;
        logic [31:0]       row;
        mm_pkg::lane_vec_t a_word;
        mm_pkg::lane_vec_t b_word;
        p = t * FIELDS;
        next_a.base       = mm_pkg::ADDR_W'(pattern[p]);
        next_a.stride     = mm_pkg::STRIDE_W'(pattern[p + 1]);
        next_b.base       = mm_pkg::ADDR_W'(pattern[p + 2]);
        next_b.stride     = mm_pkg::STRIDE_W'(pattern[p + 3]);
        next_c.base       = mm_pkg::ADDR_W'(pattern[p + 4]);
        next_c.stride     = mm_pkg::STRIDE_W'(pattern[p + 5]);
        next_masks.a_rows = N'(pattern[p + 6]);
        next_masks.inner  = N'(pattern[p + 7]);
        next_masks.b_cols = N'(pattern[p + 8]);
        for (int i = 0; i < N; i++) begin
            row = pattern[p + 9 + i];
            for (int k = 0; k < N; k++) begin
                a_mat[i][k] = row[31 - 8 * k -: 8];
            end
            row = pattern[p + 13 + i];
            for (int k = 0; k < N; k++) begin
                b_mat[i][k] = row[31 - 8 * k -: 8];
            end
        end
        // Word k holds column k of A and row k of B
        for (int k = 0; k < N; k++) begin
            for (int i = 0; i < N; i++) begin
                a_word[i] = a_mat[i][k];
                b_word[i] = b_mat[k][i];
            end
            a_mem[mm_pkg::ADDR_W'(next_a.base + k * next_a.stride)] = a_word;
            b_mem[mm_pkg::ADDR_W'(next_b.base + k * next_b.stride)] = b_word;
        end
        for (int j = 0; j < N; j++) begin
            for (int i = 0; i < N; i++) begin
                exp_col[j][i] = model_element(i, j);
            end
        end
    endtask

    task automatic run_test(input int t);
        int                        edges;
        int                        words;
        int                        step;
        logic                      finished;
        logic [mm_pkg::ADDR_W-1:0] exp_addr;
        mat_a         = next_a;
        mat_b         = next_b;
        mat_c         = next_c;
        masks         = next_masks;
        start_mat_mul = 1'b1;
        edges         = 0;
        words         = 0;
        finished      = 1'b0;
        while (!finished) begin
            @(negedge clk);
            edges++;
            // Fetch k reads base plus k strides, after the last one the address parks below base
            step = (edges <= N) ? edges - 1 : -1;
            check_value("a_addr", a_addr, mm_pkg::ADDR_W'(next_a.base + step * next_a.stride));
            check_value("b_addr", b_addr, mm_pkg::ADDR_W'(next_b.base + step * next_b.stride));
            if (c_data_available) begin
                if (words == N) begin
                    $display("Test %0d put out more than %0d C words", t, N);
                    stop_with_failure();
                end
                exp_addr = mm_pkg::ADDR_W'(next_c.base + words * next_c.stride);
                check_value("c_data_available cycle", edges, FIRST_WORD_CYCLE + words);
                check_value("c_addr", c_addr, exp_addr);
                check_value("c_data_out", c_data_out, exp_col[words]);
                words++;
            end
            if (done_mat_mul) begin
                check_value("done_mat_mul cycle", edges, DONE_PULSE_CYCLE);
                check_value("C word count", words, N);
                finished = 1'b1;
            end
        end
        @(negedge clk);
        check_value("done_mat_mul", done_mat_mul, 0);
        check_value("c_data_available", c_data_available, 0);
        check_value("c_data_out", c_data_out, 0);
        start_mat_mul = 1'b0;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int gap;
        void'($urandom(48));
        reset         = 1'b1;
        start_mat_mul = 1'b0;
        mat_a         = '0;
        mat_b         = '0;
        mat_c         = '0;
        masks         = '0;
        a_data        = '0;
        b_data        = '0;
        a_addr_q      = '0;
        b_addr_q      = '0;
        tests_loaded  = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            a_mem[a] = fill_word(a, 'h3c);
            b_mem[a] = fill_word(a, 'hc5);
        end
        for (int p = 0; p < MAX_TESTS * FIELDS; p++) begin
            pattern[p] = '1;
        end
        $readmemh("verif/mm_patterns.txt", pattern);
        num_tests = 0;
        while (num_tests < MAX_TESTS && pattern[num_tests * FIELDS] !== 32'hffff_ffff) begin
            num_tests++;
        end
        tests_loaded = 1'b1;
        if (num_tests == 0) begin
            $display("No test case was found in verif/mm_patterns.txt");
            stop_with_failure();
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            gap = 1 + int'($urandom % 4);
            repeat (gap) @(negedge clk);
            // Nothing may be left over from the previous run while idle
            check_value("c_data_out", c_data_out, 0);
            check_value("c_data_available", c_data_available, 0);
            check_value("done_mat_mul", done_mat_mul, 0);
            load_test(t);
            run_test(t);
        end
        $display("Regression passed");
        $finish;
    end

    // Each test gets a fixed budget of cycles
    initial begin
        wait (tests_loaded == 1'b1);
        repeat (num_tests * (mm_pkg::DONE_CYCLE + 30)) @(posedge clk);
        $display("Timeout: %0d tests did not finish in %0d clock cycles",
                 num_tests, num_tests * (mm_pkg::DONE_CYCLE + 30));
        stop_with_failure();
    end

endmodule

`default_nettype wire

/* verif/mm_patterns.txt */
// a_base a_stride b_base b_stride c_base c_stride a_rows inner b_cols
// Then A rows 0 to 3 and B rows 0 to 3, each row with column 0 in the top byte
000 01 100 01 200 01 f f f 01020304 05060708 090a0b0c 0d0e0f10 11121314 15161718 191a1b1c 1d1e1f20
010 01 020 01 030 01 f f f 3a7c19e2 c4058b61 ff80d3a9 5e27b0f4 9d14e6c8 7bfe2a53 08c1974d e36f5a1b
040 02 080 03 0c0 04 f f f ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
100 05 180 07 200 09 f f f 01000000 00010000 00000100 00000001 a1b2c3d4 e5f60718 293a4b5c 6d7e8f90
3f0 2a 005 3d 3f8 08 f f f 80808080 7f7f7f7f 40c020e0 10305070 91a2b3c4 d5e6f708 192a3b4c 5d6e7f80
020 04 060 04 0a0 04 b f f 6b2d90ee 13c7a458 f0e1d2c3 2468ace0 b4a59687 0f1e2d3c 97531fdb 48c6e20a
020 04 060 04 0a0 04 5 f f d7e8c9ba 5c4d3e2f a0b1c2d3 e4f50617 2b3c4d5e 8f9eadbc cbdaedfc 11223344
020 04 060 04 0a0 04 f f 6 c0ffee11 badc0de5 7a6b5c4d 99887766 fedcba98 01234567 89abcdef 76543210
150 10 250 20 350 30 f e f 3f2e1d0c a5b6c7d8 e9fa0b1c 2d3e4f50 61728394 a5b6c7d8 e9fa0b1c 5a5a5a5a
150 10 250 20 350 30 f 9 f 4c3b2a19 d0e1f203 14253647 58697a8b 9cadbecf e0f10213 24354657 68798a9b
155 13 2c0 1f 0f0 08 a 7 d 83a1c5e7 09b2d4f6 6e5d4c3b 2a190817 f1e2d3c4 b5a69788 796a5b4c 3d2e1f00
155 13 2c0 1f 0f0 08 f f f 10203040 50607080 90a0b0c0 d0e0f0ff 0f1f2f3f 4f5f6f7f 8f9fafbf cfdfefff
000 0c 040 0c 080 0c 0 0 0 aabbccdd eeff0011 22334455 66778899 13579bdf 2468ace0 fdb97531 0eca8642
000 0c 040 0c 080 0c f 0 f 55aa55aa aa55aa55 c3c3c3c3 3c3c3c3c 9966cc33 6699cc33 e71881ff 7e8124db
2a0 03 1c0 05 0e0 0b 3 c 9 fe01fd02 fc03fb04 fa05f906 f807f708 e0e1e2e3 c0c1c2c3 a0a1a2a3 80818283
2a0 03 1c0 05 0e0 0b f f f 0a0b0c0d 1a1b1c1d 2a2b2c2d 3a3b3c3d 4a4b4c4d 5a5b5c5d 6a6b6c6d 7a7b7c7d

/* sources.f */
logic/mm_pkg.sv
logic/mm_sequencer.sv
logic/operand_feeder.sv
logic/processing_element.sv
logic/pe_array.sv
logic/result_drain.sv
logic/mm_top.sv
verif/mm_assertions.sv
verif/mm_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module mm_tb -f sources.f || exit 1
sim_out=$(./obj_dir/Vmm_tb 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "Regression passed" && exit 0 || exit 1
